// File: source/fetch_pkg.sv
package fetch_pkg;

	// byte address and instruction word
	typedef logic [31:0] addr_t;
	typedef logic [31:0] word_t;

	// reset pc
	localparam addr_t ENTRY_ADDR = 32'h3000_0000;

	// cache geometry, 16 lines of 32 bytes
	localparam int LINE_WORDS = 8;
	localparam int OFFSET_BITS = 5;
	localparam int INDEX_BITS = 4;
	localparam int TAG_BITS = 32 - INDEX_BITS - OFFSET_BITS;

	localparam int NUM_LINES = 1 << INDEX_BITS;

	// word select inside a line, above the two byte bits
	localparam int WORD_SEL_BITS = OFFSET_BITS - 2;

	// lowest tag bit in an address
	localparam int TAG_LSB = OFFSET_BITS + INDEX_BITS;

	// refill burst is INCR and fixed at one line
	// the memory side ends it with rlast on this beat count
	localparam int BURST_BEATS = LINE_WORDS;

endpackage

// File: source/icache.sv
`timescale 1ns/1ps

module icache (
	input  logic             clock,
	input  logic             reset,

	// lookup, answered one cycle later
	input  fetch_pkg::addr_t lookup_addr,
	output logic             hit,
	output fetch_pkg::word_t rdata,

	// refill, one word per cycle in address order
	input  logic             fill_valid,
	input  fetch_pkg::addr_t fill_addr,
	input  fetch_pkg::word_t fill_data
);

	// arrays
	fetch_pkg::word_t data_mem [fetch_pkg::NUM_LINES * fetch_pkg::LINE_WORDS];
	logic [fetch_pkg::TAG_BITS-1:0] tag_mem [fetch_pkg::NUM_LINES];
	logic [fetch_pkg::NUM_LINES-1:0] line_valid;

	// registered lookup address
	fetch_pkg::addr_t lookup_q;

	logic [fetch_pkg::INDEX_BITS-1:0] lookup_index;
	logic [fetch_pkg::WORD_SEL_BITS-1:0] lookup_word;
	logic [fetch_pkg::TAG_BITS-1:0] lookup_tag;

	logic [fetch_pkg::INDEX_BITS-1:0] fill_index;
	logic [fetch_pkg::WORD_SEL_BITS-1:0] fill_word;
	logic [fetch_pkg::TAG_BITS-1:0] fill_tag;

	logic fill_first;
	logic fill_final;

	assign lookup_index = lookup_q[fetch_pkg::TAG_LSB-1:fetch_pkg::OFFSET_BITS];
	assign lookup_word = lookup_q[fetch_pkg::OFFSET_BITS-1:2];
	assign lookup_tag = lookup_q[31:fetch_pkg::TAG_LSB];

	assign fill_index = fill_addr[fetch_pkg::TAG_LSB-1:fetch_pkg::OFFSET_BITS];
	assign fill_word = fill_addr[fetch_pkg::OFFSET_BITS-1:2];
	assign fill_tag = fill_addr[31:fetch_pkg::TAG_LSB];

	// first and last word of a line refill
	assign fill_first = fill_valid && (fill_word == '0);
	assign fill_final = fill_valid &&
		(fill_word == fetch_pkg::WORD_SEL_BITS'(fetch_pkg::LINE_WORDS - 1));

	always_ff @(posedge clock) begin
		lookup_q <= lookup_addr;
	end

	always_ff @(posedge clock) begin
		if (fill_valid) begin
			data_mem[{fill_index, fill_word}] <= fill_data;
		end
	end

	always_ff @(posedge clock) begin
		if (fill_final) begin
			tag_mem[fill_index] <= fill_tag;
		end
	end

	// line goes invalid while its words are being replaced,
	// so a stale tag never hits on half-written data
	always_ff @(posedge clock) begin
		if (reset) begin
			line_valid <= '0;
		end else if (fill_final) begin
			line_valid[fill_index] <= 1'b1;
		end else if (fill_first) begin
			line_valid[fill_index] <= 1'b0;
		end
	end

	// compare against the arrays as they are now, so a word
	// written in the previous cycle is already seen
	assign hit = line_valid[lookup_index] && (tag_mem[lookup_index] == lookup_tag);
	assign rdata = data_mem[{lookup_index, lookup_word}];

endmodule

// File: source/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
	input  logic             clock,
	input  logic             reset,

	// memory read channel
	output fetch_pkg::addr_t araddr,
	output logic             arvalid,
	input  logic             arready,
	input  fetch_pkg::word_t rdata,
	input  logic             rvalid,
	input  logic             rlast,

	// icache lookup and fill
	output fetch_pkg::addr_t lookup_addr,
	input  logic             cache_hit,
	input  fetch_pkg::word_t cache_rdata,
	output logic             fill_valid,
	output fetch_pkg::addr_t fill_addr,
	output fetch_pkg::word_t fill_data,

	// execute side
	input  logic             redirect,
	input  fetch_pkg::addr_t redirect_addr,
	input  fetch_pkg::addr_t dnpc,

	// decode side
	output fetch_pkg::addr_t pc_out,
	output fetch_pkg::word_t inst,
	output logic             inst_valid,
	input  logic             inst_ready
);

	fetch_pkg::addr_t pc;
	fetch_pkg::addr_t beat_addr;

	// lookup_start: pc is presented to the cache this cycle
	// lookup_pending: cache answer for pc is on hit/rdata
	logic lookup_start;
	logic lookup_pending;
	logic redirect_pending;

	logic squash;
	logic lookup_miss;
	logic refill_done;
	logic fetch_end;
	logic beat_match;

	assign lookup_addr = pc;
	assign pc_out = pc;

	// beat_addr sits on the line start until the first beat
	assign araddr = beat_addr;

	assign squash = redirect | redirect_pending;

	// a squashed lookup never goes to memory
	assign lookup_miss = lookup_pending & ~cache_hit & ~squash;
	assign refill_done = rvalid & rlast;

	// hit, squashed lookup or last refill beat
	assign fetch_end = (lookup_pending & ~lookup_miss) | refill_done;

	assign beat_match =
		beat_addr[fetch_pkg::OFFSET_BITS-1:2] == pc[fetch_pkg::OFFSET_BITS-1:2];

	always_ff @(posedge clock) begin
		if (reset) begin
			pc <= fetch_pkg::ENTRY_ADDR;
			lookup_start <= 1'b1;
			lookup_pending <= 1'b0;
			redirect_pending <= 1'b0;
			arvalid <= 1'b0;
			fill_valid <= 1'b0;
			inst_valid <= 1'b0;
		end else begin
			lookup_pending <= lookup_start;
			lookup_start <= 1'b0;

			// every beat goes to the cache the next cycle
			fill_valid <= rvalid;

			if (lookup_miss) begin
				arvalid <= 1'b1;
			end else if (arready) begin
				arvalid <= 1'b0;
			end

			if (inst_valid) begin
				// decode slot full, a redirect drops it at once
				if (redirect) begin
					pc <= redirect_addr;
					inst_valid <= 1'b0;
					lookup_start <= 1'b1;
				end else if (inst_ready) begin
					pc <= dnpc;
					inst_valid <= 1'b0;
					lookup_start <= 1'b1;
				end
			end else if (fetch_end) begin
				redirect_pending <= 1'b0;
				if (squash) begin
					// restart at the target, nothing goes to decode
					lookup_start <= 1'b1;
					if (redirect) begin
						pc <= redirect_addr;
					end
				end else begin
					inst_valid <= 1'b1;
				end
			end else if (redirect) begin
				// fetch in flight keeps going; pc already holds the target
				pc <= redirect_addr;
				redirect_pending <= 1'b1;
			end
		end
	end

	// refill beat address, line aligned on a miss
	always_ff @(posedge clock) begin
		if (lookup_miss) begin
			beat_addr <= {pc[31:fetch_pkg::OFFSET_BITS], {fetch_pkg::OFFSET_BITS{1'b0}}};
		end else if (rvalid) begin
			beat_addr <= beat_addr + 32'd4;
		end
	end

	always_ff @(posedge clock) begin
		if (rvalid) begin
			fill_addr <= beat_addr;
			fill_data <= rdata;
		end
	end

	// inst only loads while inst_valid is low
	always_ff @(posedge clock) begin
		if (lookup_pending && cache_hit) begin
			inst <= cache_rdata;
		end else if (rvalid && beat_match) begin
			inst <= rdata;
		end
	end

endmodule

// File: source/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
	input  logic             clock,
	input  logic             reset,

	// memory read channel
	output fetch_pkg::addr_t araddr,
	output logic             arvalid,
	input  logic             arready,
	input  fetch_pkg::word_t rdata,
	input  logic             rvalid,
	input  logic             rlast,

	// execute side
	input  logic             redirect,
	input  fetch_pkg::addr_t redirect_addr,
	input  fetch_pkg::addr_t dnpc,

	// decode side
	input  logic             inst_ready,
	output logic             inst_valid,
	output fetch_pkg::word_t inst,
	output fetch_pkg::addr_t pc_out
);

	fetch_pkg::addr_t lookup_addr;
	logic cache_hit;
	fetch_pkg::word_t cache_rdata;
	logic fill_valid;
	fetch_pkg::addr_t fill_addr;
	fetch_pkg::word_t fill_data;

	fetch_unit u_fetch (
		.clock(clock),
		.reset(reset),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rvalid(rvalid),
		.rlast(rlast),
		.lookup_addr(lookup_addr),
		.cache_hit(cache_hit),
		.cache_rdata(cache_rdata),
		.fill_valid(fill_valid),
		.fill_addr(fill_addr),
		.fill_data(fill_data),
		.redirect(redirect),
		.redirect_addr(redirect_addr),
		.dnpc(dnpc),
		.pc_out(pc_out),
		.inst(inst),
		.inst_valid(inst_valid),
		.inst_ready(inst_ready)
	);

	icache u_icache (
		.clock(clock),
		.reset(reset),
		.lookup_addr(lookup_addr),
		.hit(cache_hit),
		.rdata(cache_rdata),
		.fill_valid(fill_valid),
		.fill_addr(fill_addr),
		.fill_data(fill_data)
	);

endmodule

// File: bench/burst_memory.sv
`timescale 1ns/1ps

module burst_memory #(
	parameter int unsigned SEED = 32'h1,
	parameter logic [31:0] KEY = 32'h0
) (
	input  logic             clock,
	input  logic             reset,
	input  fetch_pkg::addr_t araddr,
	input  logic             arvalid,
	output logic             arready,
	output fetch_pkg::word_t rdata,
	output logic             rvalid,
	output logic             rlast
);

	fetch_pkg::addr_t base;
	int beat;
	logic busy;

	// takes one line request at a time
	initial begin
		logic ar_fire;
		logic beat_fire;
		fetch_pkg::addr_t ar_addr;
		arready = 1'b0;
		rvalid = 1'b0;
		rlast = 1'b0;
		rdata = '0;
		base = '0;
		beat = 0;
		busy = 1'b0;
		void'($urandom(SEED));
		forever begin
			@(posedge clock);
			ar_fire = arvalid && arready;
			ar_addr = araddr;
			beat_fire = rvalid;
			#1;
			if (reset) begin
				busy = 1'b0;
				beat = 0;
			end else if (ar_fire) begin
				base = ar_addr;
				beat = 0;
				busy = 1'b1;
			end else if (beat_fire) begin
				if (beat == fetch_pkg::BURST_BEATS - 1) begin
					busy = 1'b0;
				end else begin
					beat++;
				end
			end
			// random stalls on arready and between beats
			if (busy) begin
				arready = 1'b0;
				rvalid = ($urandom % 4) != 0;
				rdata = (base + 32'(beat * 4)) ^ KEY;
				rlast = (beat == fetch_pkg::BURST_BEATS - 1);
			end else begin
				arready = !reset && (($urandom % 3) != 0);
				rvalid = 1'b0;
				rlast = 1'b0;
			end
		end
	end

endmodule

// File: bench/fetch_chk.sv
`timescale 1ns/1ps

module fetch_chk (
	input logic             clock,
	input logic             reset,
	input logic             arvalid,
	input logic             arready,
	input logic             rvalid,
	input logic             fill_valid,
	input logic             redirect,
	input logic             inst_valid,
	input logic             inst_ready,
	input fetch_pkg::addr_t pc_out,
	input fetch_pkg::word_t inst
);

	int unsigned failures = 0;

	// request stays up until taken
	assert property (@(posedge clock) disable iff (reset)
		arvalid && !arready |=> arvalid)
	else begin
		$error("arvalid dropped before arready");
		failures++;
	end

	// decode slot holds while stalled, unless a redirect drops it
	assert property (@(posedge clock) disable iff (reset)
		inst_valid && !inst_ready && !redirect |=>
			inst_valid && $stable(inst) && $stable(pc_out))
	else begin
		$error("decode output changed while stalled");
		failures++;
	end

	assert property (@(posedge clock) disable iff (reset)
		$rose(fill_valid) |-> $past(rvalid))
	else begin
		$error("fill without a beat in the previous cycle");
		failures++;
	end

endmodule

bind fetch_unit fetch_chk u_chk (
	.clock(clock),
	.reset(reset),
	.arvalid(arvalid),
	.arready(arready),
	.rvalid(rvalid),
	.fill_valid(fill_valid),
	.redirect(redirect),
	.inst_valid(inst_valid),
	.inst_ready(inst_ready),
	.pc_out(pc_out),
	.inst(inst)
);

// File: bench/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;

	localparam logic [31:0] MEM_KEY = 32'h1454_0000;
	localparam int unsigned RANDOM_SEED = 32'h1454_ba3e;
	// about 40 fetches, a refill with stalls stays well under 500 cycles
	localparam int FETCH_COUNT = 40;
	localparam int CYCLES_PER_FETCH = 500;
	localparam int TIMEOUT_CYCLES = FETCH_COUNT * CYCLES_PER_FETCH;
	localparam int HIT_LATENCY = 2;
	localparam fetch_pkg::addr_t ENTRY = fetch_pkg::ENTRY_ADDR;

	logic clock;
	logic reset;
	fetch_pkg::addr_t araddr;
	logic arvalid;
	logic arready;
	fetch_pkg::word_t rdata;
	logic rvalid;
	logic rlast;
	logic redirect;
	fetch_pkg::addr_t redirect_addr;
	fetch_pkg::addr_t dnpc;
	logic inst_ready;
	logic inst_valid;
	fetch_pkg::word_t inst;
	fetch_pkg::addr_t pc_out;

	int value_errors = 0;
	int other_errors = 0;
	int request_count = 0;
	fetch_pkg::addr_t request_addr = '0;
	int cycle_count = 0;
	int last_wait = 0;

	fetch_top dut (
		.clock(clock),
		.reset(reset),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rvalid(rvalid),
		.rlast(rlast),
		.redirect(redirect),
		.redirect_addr(redirect_addr),
		.dnpc(dnpc),
		.inst_ready(inst_ready),
		.inst_valid(inst_valid),
		.inst(inst),
		.pc_out(pc_out)
	);

	burst_memory #(.SEED(RANDOM_SEED), .KEY(MEM_KEY)) memory (
		.clock(clock),
		.reset(reset),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rvalid(rvalid),
		.rlast(rlast)
	);

	initial clock = 1'b0;
	always #50 clock = ~clock;

	// accepted line requests
	always @(posedge clock) begin
		if (!reset && arvalid && arready) begin
			request_count <= request_count + 1;
			request_addr <= araddr;
		end
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout, no instruction after %0d cycles", cycle_count);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	function automatic fetch_pkg::word_t mem_word(input fetch_pkg::addr_t addr);
		return addr ^ MEM_KEY;
	endfunction

	function automatic fetch_pkg::addr_t line_base(input fetch_pkg::addr_t addr);
		return addr & ~32'h1f;
	endfunction

	task automatic next_cycle();
		@(posedge clock);
		#1;
	endtask

	task automatic check_addr(input string name, input fetch_pkg::addr_t got,
		input fetch_pkg::addr_t expected);
		if (got !== expected) begin
			$display("ERROR %s: got %h, expected %h", name, got, expected);
			value_errors++;
		end
	endtask

	task automatic check_word(input string name, input fetch_pkg::word_t got,
		input fetch_pkg::word_t expected);
		if (got !== expected) begin
			$display("ERROR %s: got %h, expected %h", name, got, expected);
			value_errors++;
		end
	endtask

	task automatic check_count(input string name, input int got, input int expected);
		if (got != expected) begin
			$display("ERROR %s: got %h, expected %h", name, got, expected);
			value_errors++;
		end
	endtask

	// wait for the next instruction, stall decode, then take it
	task automatic take_inst(input fetch_pkg::addr_t expected_pc, input int hold_cycles);
		fetch_pkg::addr_t held_pc;
		fetch_pkg::word_t held_inst;
		last_wait = 0;
		while (!inst_valid) begin
			next_cycle();
			last_wait++;
		end
		check_addr("pc_out", pc_out, expected_pc);
		check_word("inst", inst, mem_word(expected_pc));
		held_pc = pc_out;
		held_inst = inst;
		repeat (hold_cycles) begin
			next_cycle();
			if (!inst_valid) begin
				$display("inst_valid dropped during a decode stall at pc %h", held_pc);
				other_errors++;
			end
			check_addr("pc_out", pc_out, held_pc);
			check_word("inst", inst, held_inst);
		end
		dnpc = pc_out + 32'd4;
		inst_ready = 1'b1;
		next_cycle();
		inst_ready = 1'b0;
	endtask

	task automatic pulse_redirect(input fetch_pkg::addr_t target);
		redirect = 1'b1;
		redirect_addr = target;
		next_cycle();
		redirect = 1'b0;
	endtask

	task automatic test_reset_fetch();
		take_inst(ENTRY, 0);
		check_count("requests", request_count, 1);
		check_addr("araddr", request_addr, line_base(ENTRY));
	endtask

	task automatic test_sequential();
		for (int i = 1; i < 8; i++) begin
			take_inst(ENTRY + 32'(i * 4), 0);
			check_count("hit latency", last_wait, HIT_LATENCY);
		end
		check_count("requests", request_count, 1);
		// same line again, all hits
		pulse_redirect(ENTRY);
		for (int i = 0; i < 8; i++) begin
			take_inst(ENTRY + 32'(i * 4), 0);
			if (i > 0) begin
				check_count("hit latency", last_wait, HIT_LATENCY);
			end
		end
		check_count("requests", request_count, 1);
	endtask

	task automatic test_line_crossing();
		take_inst(ENTRY + 32'h20, 0);
		check_count("requests", request_count, 2);
		check_addr("araddr", request_addr, ENTRY + 32'h20);
		// miss in the middle of a line
		pulse_redirect(ENTRY + 32'h1054);
		take_inst(ENTRY + 32'h1054, 0);
		check_count("requests", request_count, 3);
		check_addr("araddr", request_addr, ENTRY + 32'h1040);
		take_inst(ENTRY + 32'h1058, 0);
		take_inst(ENTRY + 32'h105c, 0);
		check_count("hit latency", last_wait, HIT_LATENCY);
		take_inst(ENTRY + 32'h1060, 0);
		check_count("requests", request_count, 4);
		check_addr("araddr", request_addr, line_base(ENTRY + 32'h1060));
	endtask

	task automatic test_back_pressure();
		take_inst(ENTRY + 32'h1064, 6);
		check_count("hit latency", last_wait, HIT_LATENCY);
		take_inst(ENTRY + 32'h1068, 0);
		check_count("hit latency", last_wait, HIT_LATENCY);
		// stall on an instruction that came from a refill
		pulse_redirect(ENTRY + 32'h2088);
		take_inst(ENTRY + 32'h2088, 5);
		check_count("requests", request_count, 5);
		take_inst(ENTRY + 32'h208c, 3);
		take_inst(ENTRY + 32'h2090, 0);
		check_count("hit latency", last_wait, HIT_LATENCY);
		check_count("requests", request_count, 5);
	endtask

	task automatic test_redirect();
		// redirect while the line request is out
		pulse_redirect(ENTRY + 32'h30a0);
		while (!arvalid) begin
			next_cycle();
		end
		pulse_redirect(ENTRY + 32'h40c4);
		take_inst(ENTRY + 32'h40c4, 0);
		check_count("requests", request_count, 7);
		check_addr("araddr", request_addr, ENTRY + 32'h40c0);
		// redirect with a hit waiting for decode
		while (!inst_valid) begin
			next_cycle();
		end
		check_addr("pc_out", pc_out, ENTRY + 32'h40c8);
		pulse_redirect(ENTRY + 32'h8);
		if (inst_valid) begin
			$display("inst_valid still high in the cycle after a redirect");
			other_errors++;
		end
		take_inst(ENTRY + 32'h8, 0);
		check_count("requests", request_count, 7);
		// squashed refill still filled its line
		pulse_redirect(ENTRY + 32'h30a4);
		take_inst(ENTRY + 32'h30a4, 0);
		check_count("requests", request_count, 7);
	endtask

	initial begin
		int assert_failures;
		reset = 1'b1;
		redirect = 1'b0;
		redirect_addr = '0;
		dnpc = ENTRY;
		inst_ready = 1'b0;
		repeat (8) @(posedge clock);
		#1;
		reset = 1'b0;
		test_reset_fetch();
		test_sequential();
		test_line_crossing();
		test_back_pressure();
		test_redirect();
		repeat (4) next_cycle();
		assert_failures = int'(dut.u_fetch.u_chk.failures);
		$display("value errors %0d, other errors %0d, assertion failures %0d",
			value_errors, other_errors, assert_failures);
		if (value_errors + other_errors + assert_failures == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// File: vlog.f
source/fetch_pkg.sv
source/icache.sv
source/fetch_unit.sv
source/fetch_top.sv
bench/burst_memory.sv
bench/fetch_chk.sv
bench/fetch_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing --assert
TOP       = fetch_tb
FILELIST  = vlog.f
OBJDIR    = obj_dir
SIM       = $(OBJDIR)/V$(TOP)
RUNFLAGS  = +verilator+error+limit+1000
LOG       = sim.log
FAIL_MSG  = ERRORS FOUND
PASS_MSG  = NO ERRORS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: build
	-./$(SIM) $(RUNFLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)
